// File: hdl/systolic_ctrl_pkg.sv
package systolic_ctrl_pkg;

    localparam int PE_ROWS_DEF = 4;   // PE array height
    localparam int PE_COLS_DEF = 4;   // PE array width
    localparam int SIZE_W_DEF  = 6;   // Width of the M, K and N fields
    localparam int ADDR_W_DEF  = 10;  // SRAM address width

    // Controller phase, shared by the FSM and everything that follows it
    typedef enum logic [1:0] {
        PH_IDLE    = 2'd0,
        PH_COMPUTE = 2'd1,
        PH_FLUSH   = 2'd2
    } phase_e;

    // Number of tiles needed to cover one matrix dimension
    function automatic int ceil_div(input int num, input int den);
        return (num + den - 1) / den;
    endfunction

endpackage

// File: hdl/tile_phase_fsm.sv
module tile_phase_fsm
    import systolic_ctrl_pkg::*;
(
    input  logic   CLK,
    input  logic   RSTn,
    input  logic   START,
    input  logic   STALL,
    input  logic   compute_done,
    input  logic   flush_done,
    input  logic   last_tile,
    output phase_e phase,
    output logic   start_tile,
    output logic   finished
);

    logic go;       // Accepted start request
    logic next_tile;

    assign go        = (phase == PH_IDLE) && START && !STALL;
    assign next_tile = (phase == PH_FLUSH) && flush_done && !last_tile && !STALL;

    assign start_tile = go || next_tile;  // Edge that enters compute
    assign finished   = (phase == PH_FLUSH) && flush_done && last_tile;

    always_ff @(posedge CLK) begin
        if (!RSTn) begin
            phase <= PH_IDLE;
        end else if (!STALL) begin
            case (phase)
                PH_IDLE: begin
                    if (START) begin
                        phase <= PH_COMPUTE;
                    end
                end
                PH_COMPUTE: begin
                    if (compute_done) begin
                        phase <= PH_FLUSH;
                    end
                end
                PH_FLUSH: begin
                    if (flush_done) begin
                        phase <= last_tile ? PH_IDLE : PH_COMPUTE;
                    end
                end
                default: phase <= PH_IDLE;
            endcase
        end
    end

    a_phase_legal: assert property (@(posedge CLK) disable iff (!RSTn)
        phase inside {PH_IDLE, PH_COMPUTE, PH_FLUSH});

endmodule

// File: hdl/phase_counter.sv
module phase_counter
    import systolic_ctrl_pkg::*;
#(
    parameter int PE_ROWS = PE_ROWS_DEF,
    parameter int SIZE_W  = SIZE_W_DEF
) (
    input  logic              CLK,
    input  logic              RSTn,
    input  logic              STALL,
    input  phase_e            phase,
    input  logic [SIZE_W-1:0] k_size,
    input  logic [SIZE_W-1:0] act_rows,
    input  logic [SIZE_W-1:0] act_cols,
    output logic [SIZE_W+1:0] count,
    output logic              compute_done,
    output logic              flush_done
);

    // Every row of the array drains one result row
    localparam logic [SIZE_W+1:0] FLUSH_END = (SIZE_W+2)'(PE_ROWS - 1);

    logic [SIZE_W+1:0] compute_end;

    // Last operand needs R + C - 2 extra cycles to cross the skewed array
    assign compute_end = {2'b00, k_size} + {2'b00, act_rows} + {2'b00, act_cols}
                       - (SIZE_W+2)'(2);

    assign compute_done = (phase == PH_COMPUTE) && (count == compute_end);
    assign flush_done   = (phase == PH_FLUSH) && (count == FLUSH_END);

    always_ff @(posedge CLK) begin
        if (!RSTn) begin
            count <= '0;
        end else if (!STALL) begin
            if (phase == PH_IDLE || compute_done || flush_done) begin
                count <= '0;  // Restart at each phase change
            end else begin
                count <= count + 1'b1;
            end
        end
    end

    // Tile sizes from the sequencer must hold while a phase runs
    a_count_bound: assert property (@(posedge CLK) disable iff (!RSTn)
        !((phase == PH_COMPUTE && count > compute_end) ||
          (phase == PH_FLUSH && count > FLUSH_END)));

endmodule

// File: hdl/tile_sequencer.sv
module tile_sequencer
    import systolic_ctrl_pkg::*;
#(
    parameter int PE_ROWS = PE_ROWS_DEF,
    parameter int PE_COLS = PE_COLS_DEF,
    parameter int SIZE_W  = SIZE_W_DEF,
    parameter int ADDR_W  = ADDR_W_DEF
) (
    input  logic              CLK,
    input  logic              RSTn,
    input  logic              STALL,
    input  logic              START,
    input  logic [SIZE_W-1:0] m_size_in,
    input  logic [SIZE_W-1:0] k_size_in,
    input  logic [SIZE_W-1:0] n_size_in,
    input  phase_e            phase,
    input  logic              start_tile,
    output logic [SIZE_W-1:0] m_size,
    output logic [SIZE_W-1:0] k_size,
    output logic [SIZE_W-1:0] n_size,
    output logic [SIZE_W-1:0] tile_row,
    output logic [SIZE_W-1:0] tile_col,
    output logic [SIZE_W-1:0] tiles_n,
    output logic [SIZE_W-1:0] act_rows,
    output logic [SIZE_W-1:0] act_cols,
    output logic [ADDR_W-1:0] out_offset,
    output logic              last_tile
);

    logic [SIZE_W-1:0] tiles_m;
    logic [SIZE_W-1:0] tiles_m_in;
    logic [SIZE_W-1:0] tiles_n_in;
    logic              load;
    logic              col_wrap;
    logic [SIZE_W-1:0] row_nxt;
    logic [SIZE_W-1:0] col_nxt;
    logic [SIZE_W-1:0] rows_left;
    logic [SIZE_W-1:0] cols_left;

    // Active lanes of a tile, capped by the array size
    function automatic logic [SIZE_W-1:0] clip(input logic [SIZE_W-1:0] left,
                                               input int lanes);
        return (int'(left) >= lanes) ? SIZE_W'(lanes) : left;
    endfunction

    assign tiles_m_in = SIZE_W'(ceil_div(int'(m_size_in), PE_ROWS));
    assign tiles_n_in = SIZE_W'(ceil_div(int'(n_size_in), PE_COLS));
    assign load       = START && !STALL && (phase == PH_IDLE);

    // Row-major walk, column id first
    assign col_wrap  = (tile_col == tiles_n - 1'b1);
    assign col_nxt   = col_wrap ? '0 : tile_col + 1'b1;
    assign row_nxt   = col_wrap ? tile_row + 1'b1 : tile_row;
    assign rows_left = m_size - SIZE_W'(int'(row_nxt) * PE_ROWS);
    assign cols_left = n_size - SIZE_W'(int'(col_nxt) * PE_COLS);
    assign last_tile = (tile_row == tiles_m - 1'b1) && col_wrap;

    always_ff @(posedge CLK) begin
        if (!RSTn) begin
            m_size     <= '0;
            k_size     <= '0;
            n_size     <= '0;
            tiles_m    <= '0;
            tiles_n    <= '0;
            tile_row   <= '0;
            tile_col   <= '0;
            act_rows   <= '0;
            act_cols   <= '0;
            out_offset <= '0;
        end else if (load) begin
            m_size     <= m_size_in;
            k_size     <= k_size_in;
            n_size     <= n_size_in;
            tiles_m    <= tiles_m_in;
            tiles_n    <= tiles_n_in;
            tile_row   <= '0;
            tile_col   <= '0;
            act_rows   <= clip(m_size_in, PE_ROWS);
            act_cols   <= clip(n_size_in, PE_COLS);
            out_offset <= '0;
        end else if (start_tile) begin
            tile_row <= row_nxt;
            tile_col <= col_nxt;
            act_rows <= clip(rows_left, PE_ROWS);
            act_cols <= clip(cols_left, PE_COLS);
            if (col_wrap) begin
                // Skip the PE_ROWS output rows of the finished row of tiles
                out_offset <= out_offset + ADDR_W'(int'(tiles_n) * PE_ROWS);
            end
        end
    end

    // FSM must stop at the last tile the counts allow
    a_tile_in_grid: assert property (@(posedge CLK) disable iff (!RSTn)
        (phase != PH_IDLE) |-> (tile_row < tiles_m) && (tile_col < tiles_n));

endmodule

// File: hdl/operand_addr_gen.sv
module operand_addr_gen
    import systolic_ctrl_pkg::*;
#(
    parameter int ADDR_W  = ADDR_W_DEF,
    parameter int PE_ROWS = PE_ROWS_DEF,
    parameter int PE_COLS = PE_COLS_DEF,
    parameter int SIZE_W  = SIZE_W_DEF
) (
    input  logic              CLK,
    input  logic              RSTn,
    input  logic              STALL,
    input  phase_e            phase,
    input  logic [SIZE_W-1:0] tile_row,
    input  logic [SIZE_W-1:0] tile_col,
    input  logic [SIZE_W-1:0] m_size,
    input  logic [SIZE_W-1:0] n_size,
    output logic [ADDR_W-1:0] opnd1_addr,
    output logic [ADDR_W-1:0] opnd2_addr
);

    logic [ADDR_W-1:0] stride1;  // Operand 1 is column-major
    logic [ADDR_W-1:0] stride2;  // Operand 2 is row-major
    logic [ADDR_W-1:0] addr1_q;
    logic [ADDR_W-1:0] addr2_q;
    phase_e            phase_q;
    logic              first;

    assign stride1 = ADDR_W'(ceil_div(int'(m_size), PE_ROWS));
    assign stride2 = ADDR_W'(ceil_div(int'(n_size), PE_COLS));
    assign first   = (phase == PH_COMPUTE) && (phase_q != PH_COMPUTE);

    always_comb begin
        if (first) begin
            opnd1_addr = ADDR_W'(tile_row);  // Tile base
            opnd2_addr = ADDR_W'(tile_col);
        end else if (phase == PH_COMPUTE) begin
            opnd1_addr = addr1_q + stride1;
            opnd2_addr = addr2_q + stride2;
        end else begin
            opnd1_addr = addr1_q;
            opnd2_addr = addr2_q;
        end
    end

    always_ff @(posedge CLK) begin
        if (!RSTn) begin
            phase_q <= PH_IDLE;
            addr1_q <= '0;
            addr2_q <= '0;
        end else if (!STALL) begin
            phase_q <= phase;
            if (phase == PH_COMPUTE) begin
                addr1_q <= opnd1_addr;
                addr2_q <= opnd2_addr;
            end
        end
    end

endmodule

// File: hdl/out_write_gen.sv
module out_write_gen
    import systolic_ctrl_pkg::*;
#(
    parameter int ADDR_W  = ADDR_W_DEF,
    parameter int PE_ROWS = PE_ROWS_DEF,
    parameter int SIZE_W  = SIZE_W_DEF
) (
    input  logic              CLK,
    input  logic              RSTn,
    input  logic              STALL,
    input  phase_e            phase,
    input  logic [ADDR_W-1:0] out_offset,
    input  logic [SIZE_W-1:0] tile_col,
    input  logic [SIZE_W-1:0] tiles_n,
    input  logic [SIZE_W-1:0] act_rows,
    input  logic [SIZE_W+1:0] count,
    output logic [ADDR_W-1:0] out_addr,
    output logic              out_we_n
);

    logic [ADDR_W-1:0] addr_q;
    logic              flushing;

    assign flushing = (phase == PH_FLUSH);

    always_comb begin
        if (flushing && count == '0) begin
            out_addr = out_offset + ADDR_W'(tile_col);
        end else if (flushing) begin
            out_addr = addr_q + ADDR_W'(tiles_n);  // Next output row
        end else begin
            out_addr = addr_q;
        end
    end

    // Rows of a short tile arrive at the end of the flush
    assign out_we_n = !(flushing && ({2'b00, act_rows} + count >= (SIZE_W+2)'(PE_ROWS)));

    always_ff @(posedge CLK) begin
        if (!RSTn) begin
            addr_q <= '0;
        end else if (!STALL && flushing) begin
            addr_q <= out_addr;
        end
    end

endmodule

// File: hdl/fifo_enable_gen.sv
module fifo_enable_gen
    import systolic_ctrl_pkg::*;
#(
    parameter int LANES  = PE_ROWS_DEF,
    parameter int SIZE_W = SIZE_W_DEF
) (
    input  phase_e            phase,
    input  logic [SIZE_W+1:0] count,
    input  logic [SIZE_W-1:0] k_size,
    output logic [LANES-1:0]  push_en,
    output logic [LANES-1:0]  pop_en
);

    logic              computing;
    logic [SIZE_W+1:0] k_ext;

    assign computing = (phase == PH_COMPUTE);
    assign k_ext     = {2'b00, k_size};

    // Lane i starts i cycles late so operands meet on the diagonal
    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            push_en[i] = computing && (count < k_ext);
            pop_en[i]  = computing && (count >= (SIZE_W+2)'(i))
                       && (count < k_ext + (SIZE_W+2)'(i));
        end
    end

endmodule

// File: hdl/systolic_ctrl_top.sv
module systolic_ctrl_top
    import systolic_ctrl_pkg::*;
#(
    parameter int PE_ROWS = PE_ROWS_DEF,
    parameter int PE_COLS = PE_COLS_DEF,
    parameter int SIZE_W  = SIZE_W_DEF,
    parameter int ADDR_W  = ADDR_W_DEF
) (
    input  logic               CLK,
    input  logic               RSTn,
    input  logic               START,
    input  logic               STALL,
    input  logic [SIZE_W-1:0]  m_size_in,
    input  logic [SIZE_W-1:0]  k_size_in,
    input  logic [SIZE_W-1:0]  n_size_in,
    output logic [ADDR_W-1:0]  opnd1_addr,
    output logic [ADDR_W-1:0]  opnd2_addr,
    output logic [ADDR_W-1:0]  out_addr,
    output logic               out_we_n,
    output logic [PE_ROWS-1:0] opnd1_push_en,
    output logic [PE_ROWS-1:0] opnd1_pop_en,
    output logic [PE_COLS-1:0] opnd2_push_en,
    output logic [PE_COLS-1:0] opnd2_pop_en,
    output logic               is_computing,
    output logic               is_flushing,
    output logic               finished
);

    phase_e            phase;
    logic              start_tile;
    logic              compute_done;
    logic              flush_done;
    logic              last_tile;
    logic [SIZE_W+1:0] count;
    logic [SIZE_W-1:0] m_size;
    logic [SIZE_W-1:0] k_size;
    logic [SIZE_W-1:0] n_size;
    logic [SIZE_W-1:0] tile_row;
    logic [SIZE_W-1:0] tile_col;
    logic [SIZE_W-1:0] tiles_n;
    logic [SIZE_W-1:0] act_rows;
    logic [SIZE_W-1:0] act_cols;
    logic [ADDR_W-1:0] out_offset;

    assign is_computing = (phase == PH_COMPUTE);
    assign is_flushing  = (phase == PH_FLUSH);

    tile_phase_fsm i_tile_phase_fsm (
        .CLK(CLK), .RSTn(RSTn), .START(START), .STALL(STALL),
        .compute_done(compute_done), .flush_done(flush_done), .last_tile(last_tile),
        .phase(phase), .start_tile(start_tile), .finished(finished)
    );

    phase_counter #(.PE_ROWS(PE_ROWS), .SIZE_W(SIZE_W)) i_phase_counter (
        .CLK(CLK), .RSTn(RSTn), .STALL(STALL), .phase(phase),
        .k_size(k_size), .act_rows(act_rows), .act_cols(act_cols),
        .count(count), .compute_done(compute_done), .flush_done(flush_done)
    );

    tile_sequencer #(
        .PE_ROWS(PE_ROWS), .PE_COLS(PE_COLS), .SIZE_W(SIZE_W), .ADDR_W(ADDR_W)
    ) i_tile_sequencer (
        .CLK(CLK), .RSTn(RSTn), .STALL(STALL), .START(START),
        .m_size_in(m_size_in), .k_size_in(k_size_in), .n_size_in(n_size_in),
        .phase(phase), .start_tile(start_tile),
        .m_size(m_size), .k_size(k_size), .n_size(n_size),
        .tile_row(tile_row), .tile_col(tile_col), .tiles_n(tiles_n),
        .act_rows(act_rows), .act_cols(act_cols),
        .out_offset(out_offset), .last_tile(last_tile)
    );

    operand_addr_gen #(
        .ADDR_W(ADDR_W), .PE_ROWS(PE_ROWS), .PE_COLS(PE_COLS), .SIZE_W(SIZE_W)
    ) i_operand_addr_gen (
        .CLK(CLK), .RSTn(RSTn), .STALL(STALL), .phase(phase),
        .tile_row(tile_row), .tile_col(tile_col),
        .m_size(m_size), .n_size(n_size),
        .opnd1_addr(opnd1_addr), .opnd2_addr(opnd2_addr)
    );

    out_write_gen #(
        .ADDR_W(ADDR_W), .PE_ROWS(PE_ROWS), .SIZE_W(SIZE_W)
    ) i_out_write_gen (
        .CLK(CLK), .RSTn(RSTn), .STALL(STALL), .phase(phase),
        .out_offset(out_offset), .tile_col(tile_col), .tiles_n(tiles_n),
        .act_rows(act_rows), .count(count),
        .out_addr(out_addr), .out_we_n(out_we_n)
    );

    // Row side of the array
    fifo_enable_gen #(.LANES(PE_ROWS), .SIZE_W(SIZE_W)) i_opnd1_fifo_en (
        .phase(phase), .count(count), .k_size(k_size),
        .push_en(opnd1_push_en), .pop_en(opnd1_pop_en)
    );

    // Column side of the array
    fifo_enable_gen #(.LANES(PE_COLS), .SIZE_W(SIZE_W)) i_opnd2_fifo_en (
        .phase(phase), .count(count), .k_size(k_size),
        .push_en(opnd2_push_en), .pop_en(opnd2_pop_en)
    );

endmodule

// File: verification/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// One expected cycle of DUT outputs
typedef struct packed {
    logic              comp;
    logic              flush;
    logic              fin;
    logic              we_n;
    logic [ADDR_W-1:0] a1;
    logic [ADDR_W-1:0] a2;
    logic [ADDR_W-1:0] oa;
    logic [LANE_W-1:0] push1;
    logic [LANE_W-1:0] pop1;
    logic [LANE_W-1:0] push2;
    logic [LANE_W-1:0] pop2;
} cycle_t;

cycle_t            exp_q[$];
logic [ADDR_W-1:0] held_a1 = '0;  // Addresses keep their last value across runs
logic [ADDR_W-1:0] held_a2 = '0;
logic [ADDR_W-1:0] held_oa = '0;

// Rows or columns a tile really covers
function automatic int lanes_left(input int size, input int id, input int pe);
    int left;
    left = size - id * pe;
    return (left < pe) ? left : pe;
endfunction

function automatic logic [LANE_W-1:0] push_mask(input int t, input int k, input int lanes);
    return (t < k) ? LANE_W'((1 << lanes) - 1) : '0;
endfunction

// Lane i opens i cycles late and stays open for K cycles
function automatic logic [LANE_W-1:0] pop_mask(input int t, input int k, input int lanes);
    logic [LANE_W-1:0] mask;
    mask = '0;
    for (int i = 0; i < lanes; i++) begin
        mask[i] = (t >= i) && (t <= k - 1 + i);
    end
    return mask;
endfunction

function automatic cycle_t idle_row();
    cycle_t c;
    c      = '0;
    c.we_n = 1'b1;
    c.a1   = held_a1;
    c.a2   = held_a2;
    c.oa   = held_oa;
    return c;
endfunction

// Unstalled cycles of one run, start edge and one spare cycle included
function automatic int run_cycles(input int m, input int k, input int n);
    int total;
    total = 3;
    for (int tr = 0; tr < (m + PE_ROWS - 1) / PE_ROWS; tr++) begin
        for (int tc = 0; tc < (n + PE_COLS - 1) / PE_COLS; tc++) begin
            total += k + lanes_left(m, tr, PE_ROWS) + lanes_left(n, tc, PE_COLS) - 1 + PE_ROWS;
        end
    end
    return total;
endfunction

// Whole expected trace, first compute cycle up to the idle cycle after finished
task automatic build_trace(input int m, input int k, input int n);
    int     tm;
    int     tn;
    int     rows;
    int     cols;
    cycle_t c;
    tm = (m + PE_ROWS - 1) / PE_ROWS;
    tn = (n + PE_COLS - 1) / PE_COLS;
    exp_q.delete();
    for (int tr = 0; tr < tm; tr++) begin
        for (int tc = 0; tc < tn; tc++) begin
            rows = lanes_left(m, tr, PE_ROWS);
            cols = lanes_left(n, tc, PE_COLS);
            for (int t = 0; t < k + rows + cols - 1; t++) begin
                held_a1 = ADDR_W'(tr + t * tm);  // Column-major operand 1
                held_a2 = ADDR_W'(tc + t * tn);
                c       = idle_row();
                c.comp  = 1'b1;
                c.push1 = push_mask(t, k, PE_ROWS);
                c.pop1  = pop_mask(t, k, PE_ROWS);
                c.push2 = push_mask(t, k, PE_COLS);
                c.pop2  = pop_mask(t, k, PE_COLS);
                exp_q.push_back(c);
            end
            for (int f = 0; f < PE_ROWS; f++) begin
                held_oa = ADDR_W'(tr * tn * PE_ROWS + tc + f * tn);
                c       = idle_row();
                c.flush = 1'b1;
                c.we_n  = !(f + rows >= PE_ROWS);  // Short tiles write at the end
                c.fin   = (tr == tm - 1) && (tc == tn - 1) && (f == PE_ROWS - 1);
                exp_q.push_back(c);
            end
        end
    end
    exp_q.push_back(idle_row());
endtask

`endif

// File: verification/tb_systolic_ctrl.sv
module tb_systolic_ctrl;

    localparam int PE_ROWS   = 4;
    localparam int PE_COLS   = 4;
    localparam int SIZE_W    = 6;
    localparam int ADDR_W    = 10;
    localparam int LANE_W    = (PE_ROWS > PE_COLS) ? PE_ROWS : PE_COLS;
    localparam int NUM_TESTS = 8;

    typedef struct packed {
        logic [8*12-1:0] name;
        int              m;
        int              k;
        int              n;
        bit              stall;
    } test_t;

    // name, M, K, N, random stalls
    localparam test_t TESTS [NUM_TESTS] = '{
        '{"one_tile",     4, 3,  4, 1'b0},
        '{"ragged",       6, 5,  7, 1'b0},
        '{"tall_thin",    9, 2,  3, 1'b0},
        '{"wide",         4, 8, 13, 1'b0},
        '{"minimal",      1, 1,  1, 1'b0},
        '{"stall_mix",   10, 4,  6, 1'b1},
        '{"stall_big",   17, 6, 11, 1'b1},
        '{"largest_grid", 63, 7, 63, 1'b1}
    };

    logic               CLK;
    logic               RSTn;
    logic               START;
    logic               STALL;
    logic [SIZE_W-1:0]  m_size_in;
    logic [SIZE_W-1:0]  k_size_in;
    logic [SIZE_W-1:0]  n_size_in;
    logic [ADDR_W-1:0]  opnd1_addr;
    logic [ADDR_W-1:0]  opnd2_addr;
    logic [ADDR_W-1:0]  out_addr;
    logic               out_we_n;
    logic [PE_ROWS-1:0] opnd1_push_en;
    logic [PE_ROWS-1:0] opnd1_pop_en;
    logic [PE_COLS-1:0] opnd2_push_en;
    logic [PE_COLS-1:0] opnd2_pop_en;
    logic               is_computing;
    logic               is_flushing;
    logic               finished;

    integer seed        = 32'h1662;
    int     limit       = 100;
    int     cycle_count = 0;

    `include "tb_model.svh"

    systolic_ctrl_top #(
        .PE_ROWS(PE_ROWS), .PE_COLS(PE_COLS), .SIZE_W(SIZE_W), .ADDR_W(ADDR_W)
    ) i_systolic_ctrl_top (
        .CLK(CLK), .RSTn(RSTn), .START(START), .STALL(STALL),
        .m_size_in(m_size_in), .k_size_in(k_size_in), .n_size_in(n_size_in),
        .opnd1_addr(opnd1_addr), .opnd2_addr(opnd2_addr),
        .out_addr(out_addr), .out_we_n(out_we_n),
        .opnd1_push_en(opnd1_push_en), .opnd1_pop_en(opnd1_pop_en),
        .opnd2_push_en(opnd2_push_en), .opnd2_pop_en(opnd2_pop_en),
        .is_computing(is_computing), .is_flushing(is_flushing), .finished(finished)
    );

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    task automatic abort_run();
        $display("TB FAILED");
        $fatal(1, "Simulation stopped");
    endtask

    always @(posedge CLK) begin
        cycle_count++;
        if (cycle_count >= limit) begin
            $display("Timeout: the controller did not finish within %0d cycles", limit);
            abort_run();
        end
    end

    task automatic check_addr(input string test, input string what,
                              input logic [ADDR_W-1:0] exp, input logic [ADDR_W-1:0] act);
        if (act !== exp) begin
            $display("[FAIL] %s %s: expected 0x%0h, actual 0x%0h", test, what, exp, act);
            abort_run();
        end
    endtask

    task automatic check_lanes(input string test, input string what,
                               input logic [LANE_W-1:0] exp, input logic [LANE_W-1:0] act);
        if (act !== exp) begin
            $display("[FAIL] %s %s: expected %b, actual %b", test, what, exp, act);
            abort_run();
        end
    endtask

    task automatic check_flag(input string test, input string what,
                              input logic exp, input logic act);
        if (act !== exp) begin
            $display("[FAIL] %s %s: expected %b, actual %b", test, what, exp, act);
            abort_run();
        end
    endtask

    task automatic compare_row(input string test, input cycle_t e);
        check_flag(test, "is_computing", e.comp, is_computing);
        check_flag(test, "is_flushing", e.flush, is_flushing);
        check_flag(test, "finished", e.fin, finished);
        check_flag(test, "out_we_n", e.we_n, out_we_n);
        check_addr(test, "opnd1_addr", e.a1, opnd1_addr);
        check_addr(test, "opnd2_addr", e.a2, opnd2_addr);
        check_addr(test, "out_addr", e.oa, out_addr);
        check_lanes(test, "opnd1_push_en", e.push1, LANE_W'(opnd1_push_en));
        check_lanes(test, "opnd1_pop_en", e.pop1, LANE_W'(opnd1_pop_en));
        check_lanes(test, "opnd2_push_en", e.push2, LANE_W'(opnd2_push_en));
        check_lanes(test, "opnd2_pop_en", e.pop2, LANE_W'(opnd2_pop_en));
    endtask

    // Expected trace only moves on cycles the DUT was not stalled
    task automatic run_test(input test_t tc);
        string name;
        int    idx;
        name = $sformatf("%0s", tc.name);
        build_trace(tc.m, tc.k, tc.n);
        @(posedge CLK);
        #1;
        START     = 1'b1;
        STALL     = 1'b0;
        m_size_in = SIZE_W'(tc.m);
        k_size_in = SIZE_W'(tc.k);
        n_size_in = SIZE_W'(tc.n);
        @(posedge CLK);
        #1;
        START = 1'b0;
        idx   = 0;
        while (idx < exp_q.size()) begin
            STALL = tc.stall && (($random(seed) & 3) == 0);
            @(negedge CLK);
            compare_row($sformatf("%s cycle %0d", name, idx), exp_q[idx]);
            if (!STALL) begin
                idx++;
            end
            @(posedge CLK);
            #1;
        end
        STALL = 1'b0;
    endtask

    initial begin
        RSTn      = 1'b0;
        START     = 1'b0;
        STALL     = 1'b0;
        m_size_in = '0;
        k_size_in = '0;
        n_size_in = '0;
        for (int i = 0; i < NUM_TESTS; i++) begin
            limit += 2 * run_cycles(TESTS[i].m, TESTS[i].k, TESTS[i].n);
        end
        repeat (2) @(posedge CLK);
        #1;
        RSTn = 1'b1;
        @(negedge CLK);
        compare_row("after_reset", idle_row());

        // START during a stall must be ignored
        @(posedge CLK);
        #1;
        START     = 1'b1;
        STALL     = 1'b1;
        m_size_in = SIZE_W'(4);
        k_size_in = SIZE_W'(2);
        n_size_in = SIZE_W'(4);
        @(posedge CLK);
        #1;
        START = 1'b0;
        STALL = 1'b0;
        @(negedge CLK);
        compare_row("start_in_stall", idle_row());

        for (int i = 0; i < NUM_TESTS; i++) begin
            run_test(TESTS[i]);
        end

        $display("TB PASSED");
        $finish;
    end

endmodule

// File: sim.f
+incdir+verification
hdl/systolic_ctrl_pkg.sv
hdl/tile_phase_fsm.sv
hdl/phase_counter.sv
hdl/tile_sequencer.sv
hdl/operand_addr_gen.sv
hdl/out_write_gen.sv
hdl/fifo_enable_gen.sv
hdl/systolic_ctrl_top.sv
verification/tb_systolic_ctrl.sv

// File: Makefile
# Verilator build and run for the systolic tile controller

VERILATOR ?= verilator
TOP       ?= tb_systolic_ctrl
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SOURCES   := $(wildcard hdl/*.sv) $(wildcard verification/*.sv) $(wildcard verification/*.svh)

.PHONY: all compile run check clean

all: check

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: compile
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)

# The log decides the result, whatever the simulator exit code was
check: run
	@if grep -q "^TB PASSED$$" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
